// ==== common/mc_bridge_macros.svh ====
`ifndef MC_BRIDGE_MACROS_SVH
`define MC_BRIDGE_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

// processor effective address
`define MC_EVA_WIDTH 32

`define MC_DATA_WIDTH 32

// network word address, byte offset already stripped
`define MC_ADDR_WIDTH 21

`define MC_CORD_WIDTH 4

//////////////////////////////////////////////////////////////////////
// mesh and cache geometry
//////////////////////////////////////////////////////////////////////

`define MC_NUM_TILES_X 4
`define MC_NUM_TILES_Y 4

// two vcache banks per column, one above and one below the tiles
`define VCACHE_BLOCK_WORDS 8

//////////////////////////////////////////////////////////////////////
// queue depths
//////////////////////////////////////////////////////////////////////

// in-flight transactions, sets the transaction id width
`define MAX_OUTSTANDING 4

`define CMD_FIFO_ELS 2

`endif

// ==== common/mc_bridge_pkg.sv ====
`include "mc_bridge_macros.svh"

package mc_bridge_pkg;

  // address and data as seen by the processor
  typedef logic [`MC_EVA_WIDTH-1:0] eva_t;
  typedef logic [`MC_DATA_WIDTH-1:0] word_t;

  // network side
  typedef logic [`MC_ADDR_WIDTH-1:0] mc_addr_t;
  typedef logic [`MC_CORD_WIDTH-1:0] cord_t;
  typedef logic [(`MC_DATA_WIDTH/8)-1:0] mask_t;

  // one id per reorder entry
  typedef logic [$clog2(`MAX_OUTSTANDING)-1:0] trans_id_t;

  // access size, same encoding as the processor's memory messages
  typedef enum logic [1:0]
  {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10
  } msg_size_e;

  // packet opcode
  typedef enum logic [1:0]
  {
    e_remote_load  = 2'b00,
    e_remote_store = 2'b01
  } mc_op_e;

  // reorder entry life cycle
  typedef enum logic [1:0]
  {
    e_rob_free     = 2'b00,
    e_rob_waiting  = 2'b01,
    e_rob_returned = 2'b10
  } rob_state_e;

endpackage

// ==== mc_bridge.f ====
+incdir+common
common/mc_bridge_pkg.sv
source/cmd_fifo.sv
xlate/dram_hash.sv
xlate/packet_builder.sv
reorder/reorder_buffer.sv
source/mc_bridge_top.sv
tb/mc_bridge_properties.sv
tb/tb_mc_bridge.sv

// ==== reorder/reorder_buffer.sv ====
`timescale 1ns/1ps
`include "mc_bridge_macros.svh"

module reorder_buffer
  (input                                 clk_i
   , input                               rst_n_i

   // allocation, together with the header of the issuing command
   , input                               alloc_i
   , input                               hdr_write_i
   , input  mc_bridge_pkg::msg_size_e    hdr_size_i
   , input  mc_bridge_pkg::eva_t         hdr_addr_i
   , output mc_bridge_pkg::trans_id_t    id_o
   , output logic                        id_v_o

   // network returns, any order
   , input                               ret_v_i
   , input  mc_bridge_pkg::trans_id_t    ret_id_i
   , input  mc_bridge_pkg::word_t        ret_data_i

   // in-order responses
   , output logic                        resp_v_o
   , output logic                        resp_write_o
   , output mc_bridge_pkg::msg_size_e    resp_size_o
   , output mc_bridge_pkg::eva_t         resp_addr_o
   , output mc_bridge_pkg::word_t        resp_data_o
   , input                               resp_yumi_i
   );

  import mc_bridge_pkg::*;

  localparam int ENTRIES = `MAX_OUTSTANDING;

  rob_state_e state_r [ENTRIES];

  // saved header and returned data per entry
  logic       write_r [ENTRIES];
  msg_size_e  size_r [ENTRIES];
  eva_t       addr_r [ENTRIES];
  word_t      data_r [ENTRIES];

  trans_id_t  alloc_id_r;
  trans_id_t  head_id_r;
  logic       retire;

  function automatic trans_id_t id_inc(trans_id_t id);
    return (id == trans_id_t'(ENTRIES - 1)) ? '0 : id + 1'b1;
  endfunction

  // ids go out and come back in the same order, so one compare each
  assign id_o     = alloc_id_r;
  assign id_v_o   = (state_r[alloc_id_r] == e_rob_free);
  assign resp_v_o = (state_r[head_id_r] == e_rob_returned);
  assign retire   = resp_v_o & resp_yumi_i;

  //////////////////////////////////////////////////////////////////////
  // entry state
  //////////////////////////////////////////////////////////////////////

  // alloc, return and retire always touch different entries
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < ENTRIES; i++)
      begin
        state_r[i] <= e_rob_free;
      end
      alloc_id_r <= '0;
      head_id_r  <= '0;
    end
    else
    begin
      if (alloc_i)
      begin
        state_r[alloc_id_r] <= e_rob_waiting;
        alloc_id_r          <= id_inc(alloc_id_r);
      end
      if (ret_v_i)
      begin
        state_r[ret_id_i] <= e_rob_returned;
      end
      if (retire)
      begin
        state_r[head_id_r] <= e_rob_free;
        head_id_r          <= id_inc(head_id_r);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // header and data storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (alloc_i)
    begin
      write_r[alloc_id_r] <= hdr_write_i;
      size_r[alloc_id_r]  <= hdr_size_i;
      addr_r[alloc_id_r]  <= hdr_addr_i;
    end
    if (ret_v_i)
    begin
      // store acks carry nothing back to the processor
      data_r[ret_id_i] <= write_r[ret_id_i] ? '0 : ret_data_i;
    end
  end

  assign resp_write_o = write_r[head_id_r];
  assign resp_size_o  = size_r[head_id_r];
  assign resp_addr_o  = addr_r[head_id_r];
  assign resp_data_o  = data_r[head_id_r];

endmodule

// ==== source/cmd_fifo.sv ====
`timescale 1ns/1ps
`include "mc_bridge_macros.svh"

module cmd_fifo
  (input                                 clk_i
   , input                               rst_n_i
   , input                               v_i
   , input                               write_i
   , input  mc_bridge_pkg::msg_size_e    size_i
   , input  mc_bridge_pkg::eva_t         addr_i
   , input  mc_bridge_pkg::word_t        data_i
   , output logic                        ready_o
   , output logic                        v_o
   , output logic                        write_o
   , output mc_bridge_pkg::msg_size_e    size_o
   , output mc_bridge_pkg::eva_t         addr_o
   , output mc_bridge_pkg::word_t        data_o
   , input                               yumi_i
   );

  import mc_bridge_pkg::*;

  localparam int ELS   = `CMD_FIFO_ELS;
  localparam int PTR_W = (ELS > 1) ? $clog2(ELS) : 1;
  localparam int CNT_W = $clog2(ELS + 1);

  logic      write_mem [ELS];
  msg_size_e size_mem [ELS];
  eva_t      addr_mem [ELS];
  word_t     data_mem [ELS];

  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [CNT_W-1:0] count_r;
  logic             enq;
  logic             deq;

  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(ELS - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign ready_o = (count_r != CNT_W'(ELS));
  assign v_o     = (count_r != '0);
  assign enq     = v_i & ready_o;
  assign deq     = v_o & yumi_i;

  // storage
  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      write_mem[wr_ptr_r] <= write_i;
      size_mem[wr_ptr_r]  <= size_i;
      addr_mem[wr_ptr_r]  <= addr_i;
      data_mem[wr_ptr_r]  <= data_i;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= ptr_inc(wr_ptr_r);
      if (deq)
        rd_ptr_r <= ptr_inc(rd_ptr_r);
      if (enq & ~deq)
        count_r <= count_r + 1'b1;
      else if (deq & ~enq)
        count_r <= count_r - 1'b1;
    end
  end

  assign write_o = write_mem[rd_ptr_r];
  assign size_o  = size_mem[rd_ptr_r];
  assign addr_o  = addr_mem[rd_ptr_r];
  assign data_o  = data_mem[rd_ptr_r];

endmodule

// ==== source/mc_bridge_top.sv ====
`timescale 1ns/1ps

module mc_bridge_top
  (input                                 clk_i
   , input                               rst_n_i

   // processor command
   , input                               cmd_v_i
   , input                               cmd_write_i
   , input  mc_bridge_pkg::msg_size_e    cmd_size_i
   , input  mc_bridge_pkg::eva_t         cmd_addr_i
   , input  mc_bridge_pkg::word_t        cmd_data_i
   , output logic                        cmd_ready_o

   // packet to the mesh
   , output logic                        pkt_v_o
   , output mc_bridge_pkg::mc_op_e       pkt_op_o
   , output mc_bridge_pkg::cord_t        pkt_x_o
   , output mc_bridge_pkg::cord_t        pkt_y_o
   , output mc_bridge_pkg::mc_addr_t     pkt_addr_o
   , output mc_bridge_pkg::trans_id_t    pkt_reg_id_o
   , output mc_bridge_pkg::word_t        pkt_data_o
   , output mc_bridge_pkg::mask_t        pkt_mask_o
   , output logic                        pkt_byte_o
   , output logic                        pkt_half_o
   , output logic [1:0]                  pkt_part_sel_o
   , input                               pkt_ready_i

   // returns from the mesh
   , input                               ret_v_i
   , input  mc_bridge_pkg::trans_id_t    ret_id_i
   , input  mc_bridge_pkg::word_t        ret_data_i

   // processor response
   , output logic                        resp_v_o
   , output logic                        resp_write_o
   , output mc_bridge_pkg::msg_size_e    resp_size_o
   , output mc_bridge_pkg::eva_t         resp_addr_o
   , output mc_bridge_pkg::word_t        resp_data_o
   , input                               resp_yumi_i
   );

  import mc_bridge_pkg::*;

  // head of the command queue
  logic      head_v;
  logic      head_write;
  msg_size_e head_size;
  eva_t      head_addr;
  word_t     head_data;

  trans_id_t free_id;
  logic      free_id_v;
  logic      issue;

  cmd_fifo u_cmd_fifo
    (.clk_i(clk_i)
     , .rst_n_i(rst_n_i)
     , .v_i(cmd_v_i)
     , .write_i(cmd_write_i)
     , .size_i(cmd_size_i)
     , .addr_i(cmd_addr_i)
     , .data_i(cmd_data_i)
     , .ready_o(cmd_ready_o)
     , .v_o(head_v)
     , .write_o(head_write)
     , .size_o(head_size)
     , .addr_o(head_addr)
     , .data_o(head_data)
     , .yumi_i(issue)
     );

  //////////////////////////////////////////////////////////////////////
  // issue
  //////////////////////////////////////////////////////////////////////

  // a packet is offered only once an id is free for it
  assign pkt_v_o = head_v & free_id_v;
  // one strobe pops the queue and allocates the id
  assign issue = pkt_v_o & pkt_ready_i;

  packet_builder u_packet_builder
    (.write_i(head_write)
     , .size_i(head_size)
     , .addr_i(head_addr)
     , .data_i(head_data)
     , .id_i(free_id)
     , .op_o(pkt_op_o)
     , .x_o(pkt_x_o)
     , .y_o(pkt_y_o)
     , .mc_addr_o(pkt_addr_o)
     , .reg_id_o(pkt_reg_id_o)
     , .data_o(pkt_data_o)
     , .mask_o(pkt_mask_o)
     , .byte_o(pkt_byte_o)
     , .half_o(pkt_half_o)
     , .part_sel_o(pkt_part_sel_o)
     );

  reorder_buffer u_reorder_buffer
    (.clk_i(clk_i)
     , .rst_n_i(rst_n_i)
     , .alloc_i(issue)
     , .hdr_write_i(head_write)
     , .hdr_size_i(head_size)
     , .hdr_addr_i(head_addr)
     , .id_o(free_id)
     , .id_v_o(free_id_v)
     , .ret_v_i(ret_v_i)
     , .ret_id_i(ret_id_i)
     , .ret_data_i(ret_data_i)
     , .resp_v_o(resp_v_o)
     , .resp_write_o(resp_write_o)
     , .resp_size_o(resp_size_o)
     , .resp_addr_o(resp_addr_o)
     , .resp_data_o(resp_data_o)
     , .resp_yumi_i(resp_yumi_i)
     );

endmodule

// ==== tb/mc_bridge_properties.sv ====
`timescale 1ns/1ps
`include "mc_bridge_macros.svh"

module mc_bridge_properties
  (input                                 clk_i
   , input                               rst_n_i
   , input                               pkt_v_i
   , input                               pkt_ready_i
   , input  mc_bridge_pkg::mc_op_e       pkt_op_i
   , input  mc_bridge_pkg::cord_t        pkt_x_i
   , input  mc_bridge_pkg::cord_t        pkt_y_i
   , input  mc_bridge_pkg::mc_addr_t     pkt_addr_i
   , input  mc_bridge_pkg::trans_id_t    pkt_reg_id_i
   , input  mc_bridge_pkg::word_t        pkt_data_i
   , input  mc_bridge_pkg::mask_t        pkt_mask_i
   , input  logic [3:0]                  pkt_info_i
   , input                               ret_v_i
   , input  mc_bridge_pkg::trans_id_t    ret_id_i
   , input                               resp_v_i
   , input                               resp_yumi_i
   , input  mc_bridge_pkg::eva_t         resp_addr_i
   , input  mc_bridge_pkg::word_t        resp_data_i
   );

  import mc_bridge_pkg::*;

  // ids between packet issue and response retire
  logic [`MAX_OUTSTANDING-1:0] busy_r;
  trans_id_t                   retire_id_r;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      busy_r      <= '0;
      retire_id_r <= '0;
    end
    else
    begin
      if (pkt_v_i && pkt_ready_i)
        busy_r[pkt_reg_id_i] <= 1'b1;
      if (resp_v_i && resp_yumi_i)
      begin
        busy_r[retire_id_r] <= 1'b0;
        retire_id_r         <= retire_id_r + 1'b1;
      end
    end
  end

  // stalled packet holds every field
  pkt_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pkt_v_i && !pkt_ready_i |=> pkt_v_i
      && $stable({pkt_op_i, pkt_x_i, pkt_y_i, pkt_addr_i, pkt_reg_id_i,
                  pkt_data_i, pkt_mask_i, pkt_info_i}))
    else $error("packet changed or dropped while stalled");

  resp_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_v_i && !resp_yumi_i |=> resp_v_i && $stable({resp_addr_i, resp_data_i}))
    else $error("response changed or dropped before yumi");

  ret_busy_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ret_v_i |-> busy_r[ret_id_i])
    else $error("return for an id that is not in flight");

endmodule

// ==== tb/mc_bridge_trace.txt ====
# write size addr data ret_data op x y mc_addr mask byte half part_sel resp_data
# all hex; size 0/1/2 is 1/2/4 bytes; op 0 load, 1 store
0 2 09000040 00000000 11223344 0 2 1 000010 0 0 0 0 11223344
0 0 1886AF37 00000000 000000AB 0 1 3 01ABCD 0 1 0 3 000000AB
0 1 01803FFE 00000000 0000BEEF 0 3 0 000FFF 0 0 1 2 0000BEEF
1 2 10000400 DEADBEEF 55555555 1 0 2 000100 F 0 0 0 00000000
1 0 08800015 000000A5 66666666 1 1 1 000005 2 0 0 0 00000000
1 1 19FFFFFE 0000CDEF 77777777 1 3 3 1FFFFF C 0 0 0 00000000
1 2 00000081 01020304 88888888 1 0 0 000020 E 0 0 0 00000000
1 1 1080000F 00009999 99999999 1 1 2 000003 8 0 0 0 00000000
0 2 80001214 00000000 A1A2A3A4 0 0 0 000095 0 0 0 0 A1A2A3A4
0 2 83FFFFBC 00000000 B1B2B3B4 0 1 5 1FFFFF 0 0 0 0 B1B2B3B4
1 2 C00001E0 12345678 CCCCCCCC 1 3 5 000008 F 0 0 0 00000000
0 1 80ABCD4E 00000000 0000D1D2 0 2 0 055E6B 0 0 1 2 0000D1D2
1 0 80077787 000000C3 DDDDDDDD 1 0 5 003BB9 8 0 0 0 00000000
0 0 82000079 00000000 000000E1 0 3 0 100006 0 1 0 1 000000E1
0 2 800001C8 00000000 F0F0F0F0 0 2 5 00000A 0 0 0 0 F0F0F0F0
1 2 09800100 CAFEF00D 12121212 1 3 1 000040 F 0 0 0 00000000
0 2 11048D14 00000000 0BADF00D 0 2 2 012345 0 0 0 0 0BADF00D
0 0 00000000 00000000 0000007F 0 0 0 000000 0 1 0 0 0000007F
1 1 19000808 0000ABCD 34343434 1 2 3 000202 3 0 0 0 00000000
0 2 80010030 00000000 5A5A5A5A 0 1 0 000804 0 0 0 0 5A5A5A5A

// ==== tb/tb_mc_bridge.sv ====
`timescale 1ns/1ps
`include "mc_bridge_macros.svh"

module tb_mc_bridge;

  import mc_bridge_pkg::*;

  localparam time CLK_PERIOD = 100;
  localparam int  MAX_CMDS   = 64;
  localparam int  SEED       = 1751;

  logic       clk;
  logic       rst_n;
  logic       cmd_v;
  logic       cmd_write;
  msg_size_e  cmd_size;
  eva_t       cmd_addr;
  word_t      cmd_data;
  logic       cmd_ready;
  logic       pkt_v;
  mc_op_e     pkt_op;
  cord_t      pkt_x;
  cord_t      pkt_y;
  mc_addr_t   pkt_addr;
  trans_id_t  pkt_reg_id;
  word_t      pkt_data;
  mask_t      pkt_mask;
  logic       pkt_byte;
  logic       pkt_half;
  logic [1:0] pkt_part_sel;
  logic       pkt_ready;
  logic       ret_v;
  trans_id_t  ret_id;
  word_t      ret_data;
  logic       resp_v;
  logic       resp_write;
  msg_size_e  resp_size;
  eva_t       resp_addr;
  word_t      resp_data;
  logic       resp_yumi;

  // one trace line per command
  logic       tr_write   [MAX_CMDS];
  msg_size_e  tr_size    [MAX_CMDS];
  eva_t       tr_addr    [MAX_CMDS];
  word_t      tr_data    [MAX_CMDS];
  word_t      tr_ret     [MAX_CMDS];
  mc_op_e     tr_op      [MAX_CMDS];
  cord_t      tr_x       [MAX_CMDS];
  cord_t      tr_y       [MAX_CMDS];
  mc_addr_t   tr_mc_addr [MAX_CMDS];
  mask_t      tr_mask    [MAX_CMDS];
  logic       tr_byte    [MAX_CMDS];
  logic       tr_half    [MAX_CMDS];
  logic [1:0] tr_part    [MAX_CMDS];
  word_t      tr_resp    [MAX_CMDS];

  // packets accepted by the network, not yet returned
  int         pend_cmd [$];
  trans_id_t  pend_id [$];

  int   num_cmds     = 0;
  int   cmd_sent     = 0;
  int   pkt_seen     = 0;
  int   resp_seen    = 0;
  int   pkt_errors   = 0;
  int   resp_errors  = 0;
  int   other_errors = 0;
  logic running      = 1'b0;
  bit   trace_ok;

  mc_bridge_top u_mc_bridge_top
    (.clk_i(clk), .rst_n_i(rst_n)
     , .cmd_v_i(cmd_v), .cmd_write_i(cmd_write), .cmd_size_i(cmd_size)
     , .cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data), .cmd_ready_o(cmd_ready)
     , .pkt_v_o(pkt_v), .pkt_op_o(pkt_op), .pkt_x_o(pkt_x), .pkt_y_o(pkt_y)
     , .pkt_addr_o(pkt_addr), .pkt_reg_id_o(pkt_reg_id), .pkt_data_o(pkt_data)
     , .pkt_mask_o(pkt_mask), .pkt_byte_o(pkt_byte), .pkt_half_o(pkt_half)
     , .pkt_part_sel_o(pkt_part_sel), .pkt_ready_i(pkt_ready)
     , .ret_v_i(ret_v), .ret_id_i(ret_id), .ret_data_i(ret_data)
     , .resp_v_o(resp_v), .resp_write_o(resp_write), .resp_size_o(resp_size)
     , .resp_addr_o(resp_addr), .resp_data_o(resp_data), .resp_yumi_i(resp_yumi)
     );

  bind mc_bridge_top mc_bridge_properties u_mc_bridge_properties
    (.clk_i(clk_i), .rst_n_i(rst_n_i)
     , .pkt_v_i(pkt_v_o), .pkt_ready_i(pkt_ready_i), .pkt_op_i(pkt_op_o)
     , .pkt_x_i(pkt_x_o), .pkt_y_i(pkt_y_o), .pkt_addr_i(pkt_addr_o)
     , .pkt_reg_id_i(pkt_reg_id_o), .pkt_data_i(pkt_data_o), .pkt_mask_i(pkt_mask_o)
     , .pkt_info_i({pkt_byte_o, pkt_half_o, pkt_part_sel_o})
     , .ret_v_i(ret_v_i), .ret_id_i(ret_id_i)
     , .resp_v_i(resp_v_o), .resp_yumi_i(resp_yumi_i)
     , .resp_addr_i(resp_addr_o), .resp_data_i(resp_data_o)
     );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // trace and reporting
  //////////////////////////////////////////////////////////////////////

  task automatic load_trace(output bit ok);
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [14];
    fd = $fopen("tb/mc_bridge_trace.txt", "r");
    if (fd == 0)
    begin
      other_errors++;
      $display("could not open the trace file tb/mc_bridge_trace.txt");
    end
    else
    begin
      while (!$feof(fd) && num_cmds < MAX_CMDS)
      begin
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#")
        begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                      f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
          if (n != 14)
          begin
            other_errors++;
            $display("trace line has %0d fields instead of 14: %s", n, line);
          end
          else
          begin
            tr_write[num_cmds]   = f[0][0];
            tr_size[num_cmds]    = msg_size_e'(f[1][1:0]);
            tr_addr[num_cmds]    = f[2];
            tr_data[num_cmds]    = f[3];
            tr_ret[num_cmds]     = f[4];
            tr_op[num_cmds]      = mc_op_e'(f[5][1:0]);
            tr_x[num_cmds]       = cord_t'(f[6]);
            tr_y[num_cmds]       = cord_t'(f[7]);
            tr_mc_addr[num_cmds] = mc_addr_t'(f[8]);
            tr_mask[num_cmds]    = mask_t'(f[9]);
            tr_byte[num_cmds]    = f[10][0];
            tr_half[num_cmds]    = f[11][0];
            tr_part[num_cmds]    = f[12][1:0];
            tr_resp[num_cmds]    = f[13];
            num_cmds++;
          end
        end
      end
      $fclose(fd);
      if (num_cmds == 0)
      begin
        other_errors++;
        $display("the trace file holds no commands");
      end
    end
    ok = (num_cmds > 0);
  endtask

  task automatic end_run();
    $display("errors: %0d packet, %0d response, %0d other",
             pkt_errors, resp_errors, other_errors);
    if (pkt_errors + resp_errors + other_errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  endtask

  task automatic compare_field(input bit is_resp, input int idx, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      if (is_resp)
        resp_errors++;
      else
        pkt_errors++;
      $display("FAILED at %0d ns: %s %0d %s is %0h, expected %0h", $time,
               is_resp ? "response" : "packet", idx, name, got, exp);
    end
  endtask

  task automatic check_packet(input int idx);
    compare_field(1'b0, idx, "op", pkt_op, tr_op[idx]);
    compare_field(1'b0, idx, "x", pkt_x, tr_x[idx]);
    compare_field(1'b0, idx, "y", pkt_y, tr_y[idx]);
    compare_field(1'b0, idx, "addr", pkt_addr, tr_mc_addr[idx]);
    // ids handed out round-robin from zero
    compare_field(1'b0, idx, "reg_id", pkt_reg_id, idx % `MAX_OUTSTANDING);
    if (tr_write[idx])
    begin
      compare_field(1'b0, idx, "data", pkt_data, tr_data[idx]);
      compare_field(1'b0, idx, "mask", pkt_mask, tr_mask[idx]);
    end
    else
    begin
      compare_field(1'b0, idx, "byte", pkt_byte, tr_byte[idx]);
      compare_field(1'b0, idx, "half", pkt_half, tr_half[idx]);
      compare_field(1'b0, idx, "part_sel", pkt_part_sel, tr_part[idx]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // per-cycle stimulus and network model
  //////////////////////////////////////////////////////////////////////

  task automatic drive_commands();
    if (cmd_v && cmd_ready)
      cmd_sent++;
    // a refused command stays on the inputs
    if (!(cmd_v && !cmd_ready))
    begin
      if (cmd_sent < num_cmds && $urandom_range(3) != 0)
      begin
        cmd_v     <= 1'b1;
        cmd_write <= tr_write[cmd_sent];
        cmd_size  <= tr_size[cmd_sent];
        cmd_addr  <= tr_addr[cmd_sent];
        cmd_data  <= tr_data[cmd_sent];
      end
      else
        cmd_v <= 1'b0;
    end
  endtask

  task automatic watch_packets();
    if (pkt_v && pkt_ready)
    begin
      assert (pkt_seen < num_cmds)
      else
      begin
        other_errors++;
        $display("the bridge sent a packet with no command left for it");
      end
      if (pkt_seen < num_cmds)
      begin
        check_packet(pkt_seen);
        pend_cmd.push_back(pkt_seen);
        pend_id.push_back(pkt_reg_id);
      end
      pkt_seen++;
    end
    pkt_ready <= ($urandom_range(2) != 0);
  endtask

  // random pick from the outstanding ids, so returns come back out of order
  task automatic send_returns();
    int pick;
    if (pend_id.size() > 0 && $urandom_range(2) == 0)
    begin
      pick = $urandom_range(pend_id.size() - 1);
      ret_v    <= 1'b1;
      ret_id   <= pend_id[pick];
      ret_data <= tr_ret[pend_cmd[pick]];
      pend_id.delete(pick);
      pend_cmd.delete(pick);
    end
    else
      ret_v <= 1'b0;
  endtask

  task automatic watch_responses();
    if (resp_v && resp_yumi)
    begin
      assert (resp_seen < num_cmds)
      else
      begin
        other_errors++;
        $display("the bridge sent a response with no command left for it");
      end
      if (resp_seen < num_cmds)
      begin
        compare_field(1'b1, resp_seen, "write", resp_write, tr_write[resp_seen]);
        compare_field(1'b1, resp_seen, "size", resp_size, tr_size[resp_seen]);
        compare_field(1'b1, resp_seen, "addr", resp_addr, tr_addr[resp_seen]);
        compare_field(1'b1, resp_seen, "data", resp_data, tr_resp[resp_seen]);
      end
      resp_seen++;
    end
    // yumi only for a response that is still there next cycle
    if (resp_v && !resp_yumi)
      resp_yumi <= ($urandom_range(1) == 0);
    else
      resp_yumi <= 1'b0;
  endtask

  always @(posedge clk)
  begin
    if (running)
    begin
      drive_commands();
      watch_packets();
      send_returns();
      watch_responses();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    cmd_v     = 1'b0;
    cmd_write = 1'b0;
    cmd_size  = e_size_4;
    cmd_addr  = '0;
    cmd_data  = '0;
    pkt_ready = 1'b0;
    ret_v     = 1'b0;
    ret_id    = '0;
    ret_data  = '0;
    resp_yumi = 1'b0;
    void'($urandom(SEED));
    load_trace(trace_ok);
    if (!trace_ok)
      end_run();
    else
    begin
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      assert (cmd_ready && !pkt_v && !resp_v)
      else
      begin
        other_errors++;
        $display("wrong state after reset: cmd_ready %b pkt_v %b resp_v %b",
                 cmd_ready, pkt_v, resp_v);
      end
      running <= 1'b1;
      wait (resp_seen >= num_cmds);
      // idle time to catch late duplicates
      repeat (20) @(posedge clk);
      assert (cmd_sent == num_cmds && pkt_seen == num_cmds && resp_seen == num_cmds)
      else
      begin
        other_errors++;
        $display("%0d commands gave %0d commands sent, %0d packets, %0d responses",
                 num_cmds, cmd_sent, pkt_seen, resp_seen);
      end
      assert (!pkt_v && !resp_v && pend_id.size() == 0)
      else
      begin
        other_errors++;
        $display("the bridge is not idle after the last response");
      end
      end_run();
    end
  end

  initial
  begin
    wait (num_cmds > 0);
    #(num_cmds * 200 * CLK_PERIOD);
    other_errors++;
    $display("timeout after %0d cycles with %0d of %0d responses",
             num_cmds * 200, resp_seen, num_cmds);
    end_run();
  end

endmodule

// ==== xlate/dram_hash.sv ====
`timescale 1ns/1ps
`include "mc_bridge_macros.svh"

module dram_hash
  (input  mc_bridge_pkg::eva_t           addr_i
   , output mc_bridge_pkg::cord_t        x_o
   , output mc_bridge_pkg::cord_t        y_o
   , output mc_bridge_pkg::mc_addr_t     mc_addr_o
   );

  import mc_bridge_pkg::*;

  // remote eva: {remote, set index, bank, word offset, byte offset}
  localparam int OFFSET_W  = $clog2(`VCACHE_BLOCK_WORDS);
  localparam int BANK_W    = $clog2(2 * `MC_NUM_TILES_X);
  localparam int X_W       = $clog2(`MC_NUM_TILES_X);
  localparam int INDEX_LSB = 2 + OFFSET_W + BANK_W;
  localparam int INDEX_W   = `MC_EVA_WIDTH - 1 - INDEX_LSB;
  localparam int SET_W     = `MC_ADDR_WIDTH - OFFSET_W;

  logic [OFFSET_W-1:0] word_offset;
  logic [BANK_W-1:0]   bank;
  logic [INDEX_W-1:0]  set_index;

  assign word_offset = addr_i[2 +: OFFSET_W];
  assign bank        = addr_i[2 + OFFSET_W +: BANK_W];
  assign set_index   = addr_i[INDEX_LSB +: INDEX_W];

  // low bank bits pick the column
  assign x_o = cord_t'(bank[X_W-1:0]);

  // top bank bit: dram row directly below the tiles, else the top edge
  assign y_o = bank[BANK_W-1] ? cord_t'(`MC_NUM_TILES_Y + 1) : '0;

  // set index resized to leave room for the word offset
  assign mc_addr_o = {SET_W'(set_index), word_offset};

endmodule

// ==== xlate/packet_builder.sv ====
`timescale 1ns/1ps
`include "mc_bridge_macros.svh"

module packet_builder
  (input                                 write_i
   , input  mc_bridge_pkg::msg_size_e    size_i
   , input  mc_bridge_pkg::eva_t         addr_i
   , input  mc_bridge_pkg::word_t        data_i
   , input  mc_bridge_pkg::trans_id_t    id_i
   , output mc_bridge_pkg::mc_op_e       op_o
   , output mc_bridge_pkg::cord_t        x_o
   , output mc_bridge_pkg::cord_t        y_o
   , output mc_bridge_pkg::mc_addr_t     mc_addr_o
   , output mc_bridge_pkg::trans_id_t    reg_id_o
   , output mc_bridge_pkg::word_t        data_o
   , output mc_bridge_pkg::mask_t        mask_o
   , output logic                        byte_o
   , output logic                        half_o
   , output logic [1:0]                  part_sel_o
   );

  import mc_bridge_pkg::*;

  localparam int X_LSB = 2 + `MC_ADDR_WIDTH;
  localparam int Y_LSB = X_LSB + `MC_CORD_WIDTH;

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  // local eva: {0, y, x, word address, byte offset}
  logic       remote;
  cord_t      y_cord;
  cord_t      x_cord;
  mc_addr_t   local_addr;
  logic [1:0] low_bits;

  cord_t      hash_x;
  cord_t      hash_y;
  mc_addr_t   hash_addr;
  mask_t      store_mask;

  assign remote     = addr_i[`MC_EVA_WIDTH-1];
  assign y_cord     = addr_i[Y_LSB +: `MC_CORD_WIDTH];
  assign x_cord     = addr_i[X_LSB +: `MC_CORD_WIDTH];
  assign local_addr = addr_i[2 +: `MC_ADDR_WIDTH];
  assign low_bits   = addr_i[1:0];

  dram_hash u_dram_hash
    (.addr_i(addr_i)
     , .x_o(hash_x)
     , .y_o(hash_y)
     , .mc_addr_o(hash_addr)
     );

  assign x_o       = remote ? hash_x : x_cord;
  assign y_o       = remote ? hash_y : y_cord;
  assign mc_addr_o = remote ? hash_addr : local_addr;
  assign reg_id_o  = id_i;

  //////////////////////////////////////////////////////////////////////
  // opcode and payload
  //////////////////////////////////////////////////////////////////////

  // byte lanes written, aligned to the offset within the word
  always_comb
  begin
    case (size_i)
      e_size_1: store_mask = mask_t'(4'h1 << low_bits);
      e_size_2: store_mask = mask_t'(4'h3 << low_bits);
      default:  store_mask = mask_t'(4'hf << low_bits);
    endcase
  end

  always_comb
  begin
    op_o       = e_remote_load;
    data_o     = '0;
    mask_o     = '0;
    byte_o     = 1'b0;
    half_o     = 1'b0;
    part_sel_o = '0;
    if (write_i)
    begin
      op_o   = e_remote_store;
      data_o = data_i;
      mask_o = store_mask;
    end
    else
    begin
      // load info, so the tile returns the right sub-word
      byte_o     = (size_i == e_size_1);
      half_o     = (size_i == e_size_2);
      part_sel_o = low_bits;
    end
  end

endmodule
